// File: Makefile
TOP := exc_err_tb
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: obj_dir/V$(TOP)

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f src.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^\*\*\* TEST PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/exc_err_checker.sv
module exc_err_checker (
	input  logic clock,
	input  logic reset,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [exc_err_pkg::apb_addr_w-1:0] paddr_i,
	input  logic [exc_err_pkg::long_w-1:0] pwdata_i,
	input  logic [exc_err_pkg::long_w-1:0] prdata_i,
	input  logic pready_i,
	input  logic pslverr_i,
	input  logic start_err_exp_i,
	output int err_count_o,
	output int check_count_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import exc_err_pkg::*;

	int err_count = 0;
	int check_count = 0;
	logic [long_w-1:0] hist_m [hist_n];
	logic [long_w-1:0] worst_m;
	logic [word_w-1:0] gain_m;
	logic [word_w-1:0] t0_m;
	logic [7:0] done_m;
	logic [long_w-1:0] pend_q [$];

	assign err_count_o = err_count;
	assign check_count_o = check_count;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic longint sat32(input longint v);
		if (v > 64'sd2147483647)
			return 64'sd2147483647;
		if (v < -64'sd2147483648)
			return -64'sd2147483648;
		return v;
	endfunction

	// One error update in plain integer arithmetic
	function automatic logic [long_w-1:0] expected_update(input logic [long_w-1:0] err,
			input logic [word_w-1:0] gain);
		longint l;
		longint n;
		longint hi;
		longint lo;
		longint m;
		longint acc;
		l = longint'($signed(err));
		n = longint'($signed(gain));
		hi = l >>> 16;
		lo = (l >>> 1) - hi * 32768;
		acc = sat32(2 * hi * n);
		m = (lo * n) >>> 15;
		if (m > 32767)
			m = 32767;
		if (m < -32768)
			m = -32768;
		acc = sat32(acc + 2 * m);
		acc = sat32(2 * acc);
		acc = sat32(acc + longint'(round_k));
		return acc[long_w-1:0];
	endfunction

	function automatic int zone_model(input int k);
		if (k / l_subfr > hist_n - 1)
			return hist_n - 1;
		return k / l_subfr;
	endfunction

	task automatic apply_update(input logic [word_w-1:0] gain, input logic [word_w-1:0] t0);
		logic [long_w-1:0] t;
		logic [long_w-1:0] worst;
		int lag;
		worst = worst_init;
		lag = int'(t0);
		if (lag < l_subfr) begin
			// Entry 0 twice, second pass on the first result
			t = expected_update(hist_m[0], gain);
			if ($signed(t) > $signed(worst))
				worst = t;
			t = expected_update(t, gain);
			if ($signed(t) > $signed(worst))
				worst = t;
		end else begin
			for (int i = zone_model(lag - l_subfr); i <= zone_model(lag - 1); i++) begin
				t = expected_update(hist_m[i], gain);
				if ($signed(t) > $signed(worst))
					worst = t;
			end
		end
		for (int i = hist_n - 1; i > 0; i--)
			hist_m[i] = hist_m[i-1];
		hist_m[0] = worst;
		worst_m = worst;
	endtask

	////////////////////////////////////////
	// Comparison
	////////////////////////////////////////
	task automatic check_value(input string name, input logic [long_w-1:0] exp,
			input logic [long_w-1:0] got);
		check_count++;
		if (exp !== got) begin
			err_count++;
			$display("error %s at %h: expected %h, got %h", name, paddr_i, exp, got);
		end
	endtask

	// Brings the model up to the completion count seen on the bus
	task automatic check_status(input logic [long_w-1:0] s);
		logic [7:0] delta;
		logic [long_w-1:0] req;
		delta = s[15:8] - done_m;
		check_count++;
		if (int'(delta) > pend_q.size()) begin
			err_count++;
			$display("error prdata_o STATUS count: expected at most %h, got %h",
				done_m + 8'(pend_q.size()), s[15:8]);
		end else begin
			repeat (delta) begin
				req = pend_q.pop_front();
				apply_update(req[31:16], req[15:0]);
				done_m++;
			end
		end
		if (s[1:0] == 2'b00 && pend_q.size() != 0) begin
			err_count++;
			$display("STATUS reports idle while %0d updates are still outstanding",
				pend_q.size());
		end
		check_value("prdata_o", 32'h0, s & 32'hFFFF_00FC);
	endtask

	function automatic bit is_mapped(input logic [apb_addr_w-1:0] a);
		return a inside {addr_gain, addr_t0, addr_ctrl, addr_status, addr_worst,
			addr_hist0, addr_hist1, addr_hist2, addr_hist3};
	endfunction

	task automatic handle_read();
		case (paddr_i)
			addr_gain: check_value("prdata_o", {16'h0, gain_m}, prdata_i);
			addr_t0: check_value("prdata_o", {16'h0, t0_m}, prdata_i);
			addr_ctrl: check_value("prdata_o", 32'h0, prdata_i);
			addr_status: check_status(prdata_i);
			addr_worst: check_value("prdata_o", worst_m, prdata_i);
			addr_hist0, addr_hist1, addr_hist2, addr_hist3:
				check_value("prdata_o", hist_m[paddr_i[3:2]], prdata_i);
			default: check_value("prdata_o", 32'h0, prdata_i);
		endcase
		check_value("pslverr_o", 32'(!is_mapped(paddr_i)), 32'(pslverr_i));
	endtask

	task automatic handle_write();
		if (paddr_i == addr_gain)
			gain_m = pwdata_i[word_w-1:0];
		if (paddr_i == addr_t0)
			t0_m = pwdata_i[word_w-1:0];
		if (paddr_i == addr_ctrl && pwdata_i[0]) begin
			check_value("pslverr_o", 32'(start_err_exp_i), 32'(pslverr_i));
			if (!start_err_exp_i)
				pend_q.push_back({gain_m, t0_m});
		end else begin
			check_value("pslverr_o", 32'(!is_mapped(paddr_i)), 32'(pslverr_i));
		end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < hist_n; i++)
				hist_m[i] = '0;
			worst_m = '0;
			gain_m = '0;
			t0_m = '0;
			done_m = '0;
			pend_q.delete();
		end else if (psel_i && penable_i) begin
			check_value("pready_o", 32'h1, 32'(pready_i));
			if (pwrite_i)
				handle_write();
			else
				handle_read();
		end
	end

endmodule

// File: dv/exc_err_tb.sv
module exc_err_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import exc_err_pkg::*;

	logic clock;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_addr_w-1:0] paddr;
	logic [long_w-1:0] pwdata;
	logic [long_w-1:0] prdata;
	logic pready;
	logic pslverr;
	logic start_err_exp;
	int err_count;
	int check_count;
	int issued = 0;
	int cycles = 0;

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	exc_err_top exc_err_top_inst (
		.clock(clock), .reset(reset),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
		.pready_o(pready), .pslverr_o(pslverr)
	);

	exc_err_checker exc_err_checker_inst (
		.clock(clock), .reset(reset),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata), .prdata_i(prdata),
		.pready_i(pready), .pslverr_i(pslverr), .start_err_exp_i(start_err_exp),
		.err_count_o(err_count), .check_count_o(check_count)
	);

	// Limit grows with every update issued
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > 60 * issued + 500) begin
			$display("run stopped after %0d cycles with %0d updates issued", cycles, issued);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////
	// APB driver
	////////////////////////////////////////
	// Tasks start and end on a falling edge
	task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [long_w-1:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clock);
		penable = 1'b1;
		@(negedge clock);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [long_w-1:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clock);
		penable = 1'b1;
		@(posedge clock);
		data = prdata;
		@(negedge clock);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_idle();
		logic [long_w-1:0] status;
		status = 32'h3;
		while (status[1:0] != 2'b00)
			apb_read(addr_status, status);
	endtask

	task automatic read_results();
		logic [long_w-1:0] data;
		apb_read(addr_worst, data);
		apb_read(addr_hist0, data);
		apb_read(addr_hist1, data);
		apb_read(addr_hist2, data);
		apb_read(addr_hist3, data);
	endtask

	task automatic run_update(input logic [word_w-1:0] gain, input logic [word_w-1:0] t0);
		apb_write(addr_gain, {16'h0, gain});
		apb_write(addr_t0, {16'h0, t0});
		issued++;
		apb_write(addr_ctrl, 32'h1);
		wait_idle();
		read_results();
	endtask

	// Every lag from 40 to 160 once in shuffled order
	task automatic lag_sweep();
		int lags [121];
		int j;
		int tmp;
		for (int i = 0; i < 121; i++)
			lags[i] = 40 + i;
		for (int i = 120; i > 0; i--) begin
			j = int'($urandom_range(i, 0));
			tmp = lags[i];
			lags[i] = lags[j];
			lags[j] = tmp;
		end
		foreach (lags[i])
			run_update(16'($urandom), 16'(lags[i]));
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	initial begin
		void'($urandom(32'h991f));
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		start_err_exp = 1'b0;
		reset = 1'b1;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// Reset values
		wait_idle();
		read_results();

		// Chained mode
		repeat (8)
			run_update(16'($urandom), 16'($urandom_range(39, 0)));

		// One or two entries per lag
		lag_sweep();

		// Drive entry 0 into the positive clamp
		repeat (24)
			run_update(16'h7FFF, 16'd40);
		repeat (6)
			run_update(16'h7FFF, 16'($urandom_range(160, 40)));
		run_update(16'h8000, 16'd100);
		run_update(16'h8000, 16'd20);

		// Three starts in a row where the last finds the request slot full
		apb_write(addr_gain, {16'h0, 16'($urandom)});
		apb_write(addr_t0, 32'd90);
		issued += 2;
		apb_write(addr_ctrl, 32'h1);
		apb_write(addr_ctrl, 32'h1);
		start_err_exp = 1'b1;
		apb_write(addr_ctrl, 32'h1);
		start_err_exp = 1'b0;
		wait_idle();
		read_results();

		// Register readback and unmapped addresses
		begin
			logic [long_w-1:0] data;
			apb_read(addr_gain, data);
			apb_read(addr_t0, data);
			apb_read(addr_ctrl, data);
			apb_read(8'h14, data);
			apb_read(8'h30, data);
			apb_read(8'hFC, data);
			apb_write(8'h40, $urandom);
		end

		repeat (4) @(negedge clock);
		$display("checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0 && check_count > 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: source/err_update_calc.sv
module err_update_calc (
	input  logic [exc_err_pkg::long_w-1:0] err_i,
	input  logic [exc_err_pkg::word_w-1:0] gain_i,
	output logic [exc_err_pkg::long_w-1:0] err_o
);
	import exc_err_pkg::*;

	function automatic logic [long_w-1:0] sat_add(input logic [long_w-1:0] a,
			input logic [long_w-1:0] b);
		logic [long_w:0] sum;
		sum = {a[long_w-1], a} + {b[long_w-1], b};
		if (sum[long_w] != sum[long_w-1])
			return sum[long_w] ? long_min : long_max;
		return sum[long_w-1:0];
	endfunction

	logic signed [word_w-1:0] hi;
	logic signed [word_w-1:0] lo;
	logic signed [word_w-1:0] gain;
	logic signed [word_w-1:0] lo_mult;
	logic signed [long_w-1:0] err_half;
	logic signed [long_w-1:0] hi_prod;
	logic signed [long_w-1:0] lo_prod;
	logic signed [long_w-1:0] lo_shr;
	logic [long_w-1:0] lo_full;
	logic [long_w-1:0] hi_term;
	logic [long_w-1:0] lo_term;
	logic [long_w-1:0] prod;
	logic [long_w-1:0] prod_shl;

	always_comb begin
		// Split into hi and a 15 bit lo
		hi = err_i[long_w-1 -: word_w];
		gain = gain_i;
		err_half = $signed(err_i) >>> 1;
		lo_full = err_half - {{1{hi[word_w-1]}}, hi, 15'd0};
		lo = lo_full[word_w-1:0];

		// L_mult(hi, gain), only -1 * -1 overflows
		hi_prod = hi * gain;
		hi_term = (hi_prod == 32'sh4000_0000) ? long_max : hi_prod <<< 1;

		// mult(lo, gain) then doubled as in L_mac
		lo_prod = lo * gain;
		lo_shr = lo_prod >>> 15;
		lo_mult = (lo_shr > 32'sd32767) ? word_max : lo_shr[word_w-1:0];
		lo_term = {{15{lo_mult[word_w-1]}}, lo_mult, 1'b0};
		prod = sat_add(hi_term, lo_term);

		// L_shl by one
		if (prod[long_w-1] != prod[long_w-2])
			prod_shl = prod[long_w-1] ? long_min : long_max;
		else
			prod_shl = {prod[long_w-2:0], 1'b0};

		err_o = sat_add(round_k, prod_shl);
	end

endmodule

// File: source/exc_err_apb.sv
module exc_err_apb (
	input  logic clock,
	input  logic reset,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [exc_err_pkg::apb_addr_w-1:0] paddr_i,
	input  logic [exc_err_pkg::long_w-1:0] pwdata_i,
	output logic [exc_err_pkg::long_w-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	output logic req_valid_o,
	input  logic req_ready_i,
	output logic [exc_err_pkg::word_w-1:0] gain_o,
	output logic [exc_err_pkg::word_w-1:0] t0_o,
	input  logic busy_i,
	input  logic done_pulse_i,
	input  logic [exc_err_pkg::long_w-1:0] worst_i,
	output logic [exc_err_pkg::hist_idx_w-1:0] hist_raddr_o,
	input  logic [exc_err_pkg::long_w-1:0] hist_rdata_i
);
	import exc_err_pkg::*;

	logic access;
	logic mapped;
	logic start_req;
	logic start_err;
	logic req_valid_q;
	logic [word_w-1:0] gain_q;
	logic [word_w-1:0] t0_q;
	logic [word_w-1:0] req_gain_q;
	logic [word_w-1:0] req_t0_q;
	logic [7:0] done_cnt_q;

	assign access = psel_i && penable_i;
	assign start_req = access && pwrite_i && (paddr_i == addr_ctrl) && pwdata_i[0];
	assign start_err = start_req && req_valid_q;

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			gain_q <= '0;
			t0_q <= '0;
			req_valid_q <= 1'b0;
			done_cnt_q <= '0;
		end else begin
			if (access && pwrite_i && paddr_i == addr_gain)
				gain_q <= pwdata_i[word_w-1:0];
			if (access && pwrite_i && paddr_i == addr_t0)
				t0_q <= pwdata_i[word_w-1:0];
			if (req_valid_q && req_ready_i)
				req_valid_q <= 1'b0;
			else if (start_req && !req_valid_q)
				req_valid_q <= 1'b1;
			if (done_pulse_i)
				done_cnt_q <= done_cnt_q + 1'b1;
		end
	end

	// Operands frozen at the start write
	always_ff @(posedge clock) begin
		if (start_req && !req_valid_q) begin
			req_gain_q <= gain_q;
			req_t0_q <= t0_q;
		end
	end

	////////////////////////////////////////
	// Read decode
	////////////////////////////////////////
	always_comb begin
		mapped = 1'b1;
		prdata_o = '0;
		case (paddr_i)
			addr_gain: prdata_o = {{(long_w-word_w){1'b0}}, gain_q};
			addr_t0: prdata_o = {{(long_w-word_w){1'b0}}, t0_q};
			addr_ctrl: prdata_o = '0;
			addr_status: prdata_o = {{(long_w-16){1'b0}}, done_cnt_q, 6'b0, req_valid_q, busy_i};
			addr_worst: prdata_o = worst_i;
			addr_hist0, addr_hist1, addr_hist2, addr_hist3: prdata_o = hist_rdata_i;
			default: mapped = 1'b0;
		endcase
	end

	assign hist_raddr_o = paddr_i[hist_idx_w+1:2];
	assign pready_o = 1'b1;
	assign pslverr_o = access && (!mapped || start_err);
	assign req_valid_o = req_valid_q;
	assign gain_o = req_gain_q;
	assign t0_o = req_t0_q;

endmodule

// File: source/exc_err_hist.sv
module exc_err_hist (
	input  logic clock,
	input  logic reset,
	input  logic [exc_err_pkg::hist_idx_w-1:0] raddr_a_i,
	output logic [exc_err_pkg::long_w-1:0] rdata_a_o,
	input  logic [exc_err_pkg::hist_idx_w-1:0] raddr_b_i,
	output logic [exc_err_pkg::long_w-1:0] rdata_b_o,
	input  logic [exc_err_pkg::hist_idx_w-1:0] raddr_c_i,
	output logic [exc_err_pkg::long_w-1:0] rdata_c_o,
	input  logic we_i,
	input  logic [exc_err_pkg::hist_idx_w-1:0] waddr_i,
	input  logic [exc_err_pkg::long_w-1:0] wdata_i
);
	import exc_err_pkg::*;

	logic [long_w-1:0] hist_q [hist_n];

	// History starts from silence
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < hist_n; i++)
				hist_q[i] <= '0;
		end else if (we_i) begin
			hist_q[waddr_i] <= wdata_i;
		end
	end

	// Scan, shift and APB ports
	assign rdata_a_o = hist_q[raddr_a_i];
	assign rdata_b_o = hist_q[raddr_b_i];
	assign rdata_c_o = hist_q[raddr_c_i];

endmodule

// File: source/exc_err_pkg.sv
package exc_err_pkg;

	////////////////////////////////////////
	// Widths and codec constants
	////////////////////////////////////////
	localparam int word_w = 16;
	localparam int long_w = 32;
	localparam int hist_n = 4;
	localparam int hist_idx_w = 2;
	localparam int l_subfr = 40;
	localparam int apb_addr_w = 8;

	localparam logic [long_w-1:0] round_k = 32'h0000_4000;
	localparam logic [long_w-1:0] worst_init = 32'hFFFF_FFFF;
	localparam logic [long_w-1:0] long_max = 32'h7FFF_FFFF;
	localparam logic [long_w-1:0] long_min = 32'h8000_0000;
	localparam logic [word_w-1:0] word_max = 16'h7FFF;

	////////////////////////////////////////
	// Register map
	////////////////////////////////////////
	localparam logic [apb_addr_w-1:0] addr_gain = 8'h00;
	localparam logic [apb_addr_w-1:0] addr_t0 = 8'h04;
	localparam logic [apb_addr_w-1:0] addr_ctrl = 8'h08;
	localparam logic [apb_addr_w-1:0] addr_status = 8'h0C;
	localparam logic [apb_addr_w-1:0] addr_worst = 8'h10;
	localparam logic [apb_addr_w-1:0] addr_hist0 = 8'h20;
	localparam logic [apb_addr_w-1:0] addr_hist1 = 8'h24;
	localparam logic [apb_addr_w-1:0] addr_hist2 = 8'h28;
	localparam logic [apb_addr_w-1:0] addr_hist3 = 8'h2C;

	// Zone of a lag, one zone per subframe length, last zone open ended
	function automatic logic [hist_idx_w-1:0] zone_of(input logic [word_w-1:0] lag);
		logic [word_w-1:0] zone;
		zone = word_w'(lag / l_subfr);
		if (zone > word_w'(hist_n - 1))
			zone = word_w'(hist_n - 1);
		return zone[hist_idx_w-1:0];
	endfunction

endpackage

// File: source/exc_err_top.sv
module exc_err_top (
	input  logic clock,
	input  logic reset,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [exc_err_pkg::apb_addr_w-1:0] paddr_i,
	input  logic [exc_err_pkg::long_w-1:0] pwdata_i,
	output logic [exc_err_pkg::long_w-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o
);
	import exc_err_pkg::*;

	logic req_valid;
	logic req_ready;
	logic job_valid;
	logic job_ready;
	logic job_chained;
	logic wb_valid;
	logic shift_busy;
	logic hist_we;
	logic done_pulse;
	logic busy;
	logic [word_w-1:0] req_gain;
	logic [word_w-1:0] req_t0;
	logic [word_w-1:0] job_gain;
	logic [hist_idx_w-1:0] job_first;
	logic [hist_idx_w-1:0] job_last;
	logic [hist_idx_w-1:0] scan_raddr;
	logic [hist_idx_w-1:0] shift_raddr;
	logic [hist_idx_w-1:0] apb_raddr;
	logic [hist_idx_w-1:0] hist_waddr;
	logic [long_w-1:0] scan_rdata;
	logic [long_w-1:0] shift_rdata;
	logic [long_w-1:0] apb_rdata;
	logic [long_w-1:0] hist_wdata;
	logic [long_w-1:0] scan_worst;
	logic [long_w-1:0] result_worst;

	// Zone slot full, scan running or shift running
	assign busy = !req_ready || !job_ready;

	exc_err_apb exc_err_apb_inst (
		.clock(clock), .reset(reset),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pready_o(pready_o), .pslverr_o(pslverr_o),
		.req_valid_o(req_valid), .req_ready_i(req_ready),
		.gain_o(req_gain), .t0_o(req_t0), .busy_i(busy),
		.done_pulse_i(done_pulse), .worst_i(result_worst),
		.hist_raddr_o(apb_raddr), .hist_rdata_i(apb_rdata)
	);

	zone_stage zone_stage_inst (
		.clock(clock), .reset(reset),
		.req_valid_i(req_valid), .req_ready_o(req_ready),
		.gain_i(req_gain), .t0_i(req_t0),
		.job_valid_o(job_valid), .job_ready_i(job_ready),
		.job_gain_o(job_gain), .job_chained_o(job_chained),
		.job_first_o(job_first), .job_last_o(job_last)
	);

	scan_stage scan_stage_inst (
		.clock(clock), .reset(reset),
		.job_valid_i(job_valid), .job_ready_o(job_ready),
		.job_gain_i(job_gain), .job_chained_i(job_chained),
		.job_first_i(job_first), .job_last_i(job_last),
		.shift_busy_i(shift_busy),
		.hist_raddr_o(scan_raddr), .hist_rdata_i(scan_rdata),
		.wb_valid_o(wb_valid), .worst_o(scan_worst)
	);

	shift_stage shift_stage_inst (
		.clock(clock), .reset(reset),
		.wb_valid_i(wb_valid), .worst_i(scan_worst), .shift_busy_o(shift_busy),
		.hist_raddr_o(shift_raddr), .hist_rdata_i(shift_rdata),
		.hist_we_o(hist_we), .hist_waddr_o(hist_waddr), .hist_wdata_o(hist_wdata),
		.done_pulse_o(done_pulse), .worst_o(result_worst)
	);

	exc_err_hist exc_err_hist_inst (
		.clock(clock), .reset(reset),
		.raddr_a_i(scan_raddr), .rdata_a_o(scan_rdata),
		.raddr_b_i(shift_raddr), .rdata_b_o(shift_rdata),
		.raddr_c_i(apb_raddr), .rdata_c_o(apb_rdata),
		.we_i(hist_we), .waddr_i(hist_waddr), .wdata_i(hist_wdata)
	);

endmodule

// File: source/scan_stage.sv
module scan_stage (
	input  logic clock,
	input  logic reset,
	input  logic job_valid_i,
	output logic job_ready_o,
	input  logic [exc_err_pkg::word_w-1:0] job_gain_i,
	input  logic job_chained_i,
	input  logic [exc_err_pkg::hist_idx_w-1:0] job_first_i,
	input  logic [exc_err_pkg::hist_idx_w-1:0] job_last_i,
	input  logic shift_busy_i,
	output logic [exc_err_pkg::hist_idx_w-1:0] hist_raddr_o,
	input  logic [exc_err_pkg::long_w-1:0] hist_rdata_i,
	output logic wb_valid_o,
	output logic [exc_err_pkg::long_w-1:0] worst_o
);
	import exc_err_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_proc,
		s_done
	} scan_state_t;

	scan_state_t state_q;
	logic chained_q;
	logic second_q;
	logic [word_w-1:0] gain_q;
	logic [hist_idx_w-1:0] idx_q;
	logic [hist_idx_w-1:0] last_q;
	logic [long_w-1:0] worst_q;
	logic [long_w-1:0] prev_q;
	logic [long_w-1:0] calc_in;
	logic [long_w-1:0] calc_out;
	logic take_job;
	logic new_worst;

	err_update_calc err_update_calc_inst (
		.err_i(calc_in),
		.gain_i(gain_q),
		.err_o(calc_out)
	);

	// Second chained pass starts from the first result
	assign calc_in = (chained_q && second_q) ? prev_q : hist_rdata_i;
	assign new_worst = $signed(calc_out) > $signed(worst_q);

	// Hold off while the shift owns the history
	assign job_ready_o = (state_q == s_idle) && !shift_busy_i;
	assign take_job = job_valid_i && job_ready_o;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= s_idle;
		end else begin
			case (state_q)
				s_idle: begin
					if (take_job)
						state_q <= s_proc;
				end
				s_proc: begin
					if (chained_q ? second_q : (idx_q == last_q))
						state_q <= s_done;
				end
				default: begin
					state_q <= s_idle;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (take_job) begin
			gain_q <= job_gain_i;
			chained_q <= job_chained_i;
			idx_q <= job_first_i;
			last_q <= job_last_i;
			second_q <= 1'b0;
			worst_q <= worst_init;
		end else if (state_q == s_proc) begin
			prev_q <= calc_out;
			if (new_worst)
				worst_q <= calc_out;
			if (chained_q)
				second_q <= 1'b1;
			else if (idx_q != last_q)
				idx_q <= idx_q + 1'b1;
		end
	end

	assign hist_raddr_o = idx_q;
	assign wb_valid_o = (state_q == s_done);
	assign worst_o = worst_q;

endmodule

// File: source/shift_stage.sv
module shift_stage (
	input  logic clock,
	input  logic reset,
	input  logic wb_valid_i,
	input  logic [exc_err_pkg::long_w-1:0] worst_i,
	output logic shift_busy_o,
	output logic [exc_err_pkg::hist_idx_w-1:0] hist_raddr_o,
	input  logic [exc_err_pkg::long_w-1:0] hist_rdata_i,
	output logic hist_we_o,
	output logic [exc_err_pkg::hist_idx_w-1:0] hist_waddr_o,
	output logic [exc_err_pkg::long_w-1:0] hist_wdata_o,
	output logic done_pulse_o,
	output logic [exc_err_pkg::long_w-1:0] worst_o
);
	import exc_err_pkg::*;

	localparam logic [hist_idx_w-1:0] step_last = hist_idx_w'(hist_n - 1);

	logic active_q;
	logic [hist_idx_w-1:0] step_q;
	logic [long_w-1:0] pend_q;
	logic [long_w-1:0] result_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			active_q <= 1'b0;
			step_q <= '0;
			result_q <= '0;
		end else if (!active_q && wb_valid_i) begin
			active_q <= 1'b1;
			step_q <= '0;
		end else if (active_q) begin
			step_q <= step_q + 1'b1;
			if (step_q == step_last) begin
				active_q <= 1'b0;
				result_q <= pend_q;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!active_q && wb_valid_i)
			pend_q <= worst_i;
	end

	// Moves 2->3, 1->2, 0->1, then worst into 0
	assign hist_raddr_o = step_last - 1'b1 - step_q;
	assign hist_waddr_o = step_last - step_q;
	assign hist_wdata_o = (step_q == step_last) ? pend_q : hist_rdata_i;
	assign hist_we_o = active_q;
	assign shift_busy_o = active_q;
	assign done_pulse_o = active_q && (step_q == step_last);
	assign worst_o = result_q;

endmodule

// File: source/zone_stage.sv
module zone_stage (
	input  logic clock,
	input  logic reset,
	input  logic req_valid_i,
	output logic req_ready_o,
	input  logic [exc_err_pkg::word_w-1:0] gain_i,
	input  logic [exc_err_pkg::word_w-1:0] t0_i,
	output logic job_valid_o,
	input  logic job_ready_i,
	output logic [exc_err_pkg::word_w-1:0] job_gain_o,
	output logic job_chained_o,
	output logic [exc_err_pkg::hist_idx_w-1:0] job_first_o,
	output logic [exc_err_pkg::hist_idx_w-1:0] job_last_o
);
	import exc_err_pkg::*;

	logic full_q;
	logic decoded_q;
	logic chained_q;
	logic [word_w-1:0] gain_q;
	logic [word_w-1:0] t0_q;
	logic [word_w-1:0] lag_off;
	logic [word_w-1:0] lag_end;
	logic [hist_idx_w-1:0] first_q;
	logic [hist_idx_w-1:0] last_q;

	assign lag_off = t0_q - word_w'(l_subfr);
	assign lag_end = t0_q - 1'b1;

	always_ff @(posedge clock) begin
		if (reset) begin
			full_q <= 1'b0;
			decoded_q <= 1'b0;
		end else if (req_valid_i && req_ready_o) begin
			full_q <= 1'b1;
			decoded_q <= 1'b0;
		end else if (full_q && !decoded_q) begin
			decoded_q <= 1'b1;
		end else if (job_valid_o && job_ready_i) begin
			full_q <= 1'b0;
			decoded_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (req_valid_i && req_ready_o) begin
			gain_q <= gain_i;
			t0_q <= t0_i;
		end
		// Negative offset selects the chained pass over entry 0
		if (full_q && !decoded_q) begin
			chained_q <= lag_off[word_w-1];
			first_q <= lag_off[word_w-1] ? '0 : zone_of(lag_off);
			last_q <= lag_off[word_w-1] ? '0 : zone_of(lag_end);
		end
	end

	assign req_ready_o = !full_q;
	assign job_valid_o = full_q && decoded_q;
	assign job_gain_o = gain_q;
	assign job_chained_o = chained_q;
	assign job_first_o = first_q;
	assign job_last_o = last_q;

endmodule

// File: src.f
source/exc_err_pkg.sv
source/err_update_calc.sv
source/zone_stage.sv
source/scan_stage.sv
source/shift_stage.sv
source/exc_err_hist.sv
source/exc_err_apb.sv
source/exc_err_top.sv
dv/exc_err_checker.sv
dv/exc_err_tb.sv
